/* source/conv_geom_pkg.sv */
// convolution geometry package with default layer size and position index types
package conv_geom_pkg;

	// default kernel and output sizes for the top level parameters
	localparam int DEF_KERNEL_W = 3;	// taps per kernel row
	localparam int DEF_KERNEL_H = 3;	// kernel rows
	localparam int DEF_OUT_W    = 4;	// output columns
	localparam int DEF_OUT_H    = 2;	// output rows

	// output column index
	typedef logic [5:0] col_t;

	// output row index
	typedef logic [5:0] row_t;

	// kernel row inside the window
	typedef logic [3:0] win_row_t;

	typedef logic [5:0] chnl_t;	// output channel pair
	typedef logic [3:0] tap_t;	// tap inside a kernel row

endpackage

/* source/conv_data_pkg.sv */
// convolution data package with sample and accumulator types and channel parallelism
package conv_data_pkg;

	// feature map sample or kernel weight
	typedef logic signed [15:0] sample_t;

	// product, channel sum, partial sum or bias that wraps on overflow
	typedef logic signed [31:0] acc_t;

	// input channels handled per tap
	localparam int FIN_PAR = 3;

	// output channels handled per tap
	localparam int FOUT_PAR = 2;

endpackage

/* source/mac_array.sv */
// tap-serial multiply-accumulate array, three input by two output channels
`timescale 1ns/100ps

module mac_array
	import conv_data_pkg::*, conv_geom_pkg::*;
#(
	parameter int KERNEL_W = 3
)
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    tap_vld,
	input  sample_t fin_ch0,
	input  sample_t fin_ch1,
	input  sample_t fin_ch2,
	input  sample_t wgt_f0_c0,
	input  sample_t wgt_f0_c1,
	input  sample_t wgt_f0_c2,
	input  sample_t wgt_f1_c0,
	input  sample_t wgt_f1_c1,
	input  sample_t wgt_f1_c2,
	output logic    mac_done,
	output acc_t    mac_f0_c0,
	output acc_t    mac_f0_c1,
	output acc_t    mac_f0_c2,
	output acc_t    mac_f1_c0,
	output acc_t    mac_f1_c1,
	output acc_t    mac_f1_c2
);

	sample_t fin [FIN_PAR];
	sample_t wgt [FOUT_PAR][FIN_PAR];
	acc_t    prod [FOUT_PAR][FIN_PAR];
	acc_t    acc [FOUT_PAR][FIN_PAR];
	tap_t    tap_cnt;
	logic    tap_last;

	assign fin[0] = fin_ch0;
	assign fin[1] = fin_ch1;
	assign fin[2] = fin_ch2;
	assign wgt[0][0] = wgt_f0_c0;
	assign wgt[0][1] = wgt_f0_c1;
	assign wgt[0][2] = wgt_f0_c2;
	assign wgt[1][0] = wgt_f1_c0;
	assign wgt[1][1] = wgt_f1_c1;
	assign wgt[1][2] = wgt_f1_c2;

	assign tap_last = (tap_cnt == tap_t'(KERNEL_W - 1));

	// tap position within the kernel row
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			tap_cnt  <= '0;
			mac_done <= 1'b0;
		end
		else
		begin
			mac_done <= tap_vld && tap_last;	// sums stay put until the next tap
			if (tap_vld)
				tap_cnt <= tap_last ? '0 : tap_cnt + 1'b1;
		end
	end

	// products sign extended to the accumulator width
	always_comb
	begin
		for (int o = 0; o < FOUT_PAR; o++)
		begin
			for (int i = 0; i < FIN_PAR; i++)
				prod[o][i] = acc_t'(fin[i]) * acc_t'(wgt[o][i]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (tap_vld)
		begin
			for (int o = 0; o < FOUT_PAR; o++)
			begin
				for (int i = 0; i < FIN_PAR; i++)
				begin
					if (tap_cnt == '0)
						acc[o][i] <= prod[o][i];	// restart on tap 0
					else
						acc[o][i] <= acc[o][i] + prod[o][i];
				end
			end
		end
	end

	assign mac_f0_c0 = acc[0][0];
	assign mac_f0_c1 = acc[0][1];
	assign mac_f0_c2 = acc[0][2];
	assign mac_f1_c0 = acc[1][0];
	assign mac_f1_c1 = acc[1][1];
	assign mac_f1_c2 = acc[1][2];

endmodule

/* source/channel_sum.sv */
// channel adder that sums input channels, adds bias or partial sum, ReLU on the last row
`timescale 1ns/100ps

module channel_sum
	import conv_data_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic mac_done,
	input  acc_t mac_f0_c0,
	input  acc_t mac_f0_c1,
	input  acc_t mac_f0_c2,
	input  acc_t mac_f1_c0,
	input  acc_t mac_f1_c1,
	input  acc_t mac_f1_c2,
	input  acc_t bias_0,
	input  acc_t bias_1,
	input  acc_t psum_0,
	input  acc_t psum_1,
	input  logic first_win_row,
	input  logic win_row_last,
	output logic psum_pop,
	output logic psum_push,
	output acc_t sum_0,
	output acc_t sum_1,
	output logic sum_vld,
	output logic fout_vld,
	output acc_t fout_ch0,
	output acc_t fout_ch1
);

	acc_t chan_0;
	acc_t chan_1;
	acc_t base_0;
	acc_t base_1;

	// negative results clamp to zero
	function automatic acc_t relu(input acc_t val);
		return val[31] ? '0 : val;
	endfunction

	assign chan_0 = mac_f0_c0 + mac_f0_c1 + mac_f0_c2;
	assign chan_1 = mac_f1_c0 + mac_f1_c1 + mac_f1_c2;

	// bias starts a window, later rows continue from the stored partial
	assign base_0 = first_win_row ? bias_0 : psum_0;
	assign base_1 = first_win_row ? bias_1 : psum_1;

	assign psum_pop  = mac_done && !first_win_row;	// head consumed while it is added
	assign psum_push = sum_vld && !win_row_last;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sum_vld  <= 1'b0;
			fout_vld <= 1'b0;
		end
		else
		begin
			sum_vld  <= mac_done;
			fout_vld <= sum_vld && win_row_last;
		end
	end

	always_ff @(posedge clk)
	begin
		if (mac_done)
		begin
			sum_0 <= base_0 + chan_0;
			sum_1 <= base_1 + chan_1;
		end
		if (sum_vld && win_row_last)
		begin
			fout_ch0 <= relu(sum_0);
			fout_ch1 <= relu(sum_1);
		end
	end

endmodule

/* source/psum_fifo.sv */
// partial sum buffer, one output row deep, head readable without latency
`timescale 1ns/100ps

module psum_fifo
	import conv_data_pkg::*;
#(
	parameter int DEPTH = 4
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic push,
	input  logic pop,
	input  acc_t din,
	output acc_t dout
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	acc_t           mem [DEPTH];
	logic [AW-1:0]  wr_ptr;
	logic [AW-1:0]  rd_ptr;

	// pointers wrap at DEPTH, which need not be a power of two
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= din;
	end

	assign dout = mem[rd_ptr];	// first word falls through

endmodule

/* source/window_counter.sv */
// column, kernel row, output row and channel pair counters for the adder stage
`timescale 1ns/100ps

module window_counter
	import conv_geom_pkg::*;
#(
	parameter int OUT_W    = 4,
	parameter int KERNEL_H = 3,
	parameter int OUT_H    = 2
)
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     sum_vld,
	output col_t     proc_col,
	output win_row_t proc_win_row,
	output row_t     proc_row,
	output chnl_t    proc_chnl,
	output logic     col_last,
	output logic     win_row_last,
	output logic     row_last,
	output logic     first_win_row
);

	assign col_last      = (proc_col == col_t'(OUT_W - 1));
	assign win_row_last  = (proc_win_row == win_row_t'(KERNEL_H - 1));
	assign row_last      = (proc_row == row_t'(OUT_H - 1));
	assign first_win_row = (proc_win_row == '0);

	// column runs fastest, then kernel row, then output row
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			proc_col     <= '0;
			proc_win_row <= '0;
			proc_row     <= '0;
			proc_chnl    <= '0;
		end
		else if (sum_vld)
		begin
			if (!col_last)
				proc_col <= proc_col + 1'b1;
			else
			begin
				proc_col <= '0;
				if (!win_row_last)
					proc_win_row <= proc_win_row + 1'b1;
				else
				begin
					proc_win_row <= '0;
					if (!row_last)
						proc_row <= proc_row + 1'b1;
					else
					begin
						proc_row  <= '0;
						proc_chnl <= proc_chnl + 1'b1;	// free running, wraps
					end
				end
			end
		end
	end

endmodule

/* source/conv_pe_top.sv */
// convolution processing element, three input and two output channels per pass
`timescale 1ns/100ps

module conv_pe_top
	import conv_data_pkg::*, conv_geom_pkg::*;
#(
	parameter int KERNEL_W = DEF_KERNEL_W,
	parameter int KERNEL_H = DEF_KERNEL_H,
	parameter int OUT_W    = DEF_OUT_W,
	parameter int OUT_H    = DEF_OUT_H
)
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     tap_vld,
	input  sample_t  fin_ch0,
	input  sample_t  fin_ch1,
	input  sample_t  fin_ch2,
	input  sample_t  wgt_f0_c0,
	input  sample_t  wgt_f0_c1,
	input  sample_t  wgt_f0_c2,
	input  sample_t  wgt_f1_c0,
	input  sample_t  wgt_f1_c1,
	input  sample_t  wgt_f1_c2,
	input  acc_t     bias_0,
	input  acc_t     bias_1,
	output logic     fout_vld,
	output acc_t     fout_ch0,
	output acc_t     fout_ch1,
	output chnl_t    proc_chnl,
	output row_t     proc_row,
	output col_t     proc_col,
	output win_row_t proc_win_row,
	output logic     col_last,
	output logic     win_row_last,
	output logic     row_last
);

	logic mac_done;
	acc_t mac_f0_c0, mac_f0_c1, mac_f0_c2;
	acc_t mac_f1_c0, mac_f1_c1, mac_f1_c2;
	logic psum_pop;
	logic psum_push;
	acc_t psum_0, psum_1;
	acc_t sum_0, sum_1;	// adder results on their way into the FIFOs
	logic sum_vld;
	logic first_win_row;

	mac_array #(.KERNEL_W(KERNEL_W)) mac_array_inst (
		.clk(clk), .rst_n(rst_n), .tap_vld(tap_vld),
		.fin_ch0(fin_ch0), .fin_ch1(fin_ch1), .fin_ch2(fin_ch2),
		.wgt_f0_c0(wgt_f0_c0), .wgt_f0_c1(wgt_f0_c1), .wgt_f0_c2(wgt_f0_c2),
		.wgt_f1_c0(wgt_f1_c0), .wgt_f1_c1(wgt_f1_c1), .wgt_f1_c2(wgt_f1_c2),
		.mac_done(mac_done),
		.mac_f0_c0(mac_f0_c0), .mac_f0_c1(mac_f0_c1), .mac_f0_c2(mac_f0_c2),
		.mac_f1_c0(mac_f1_c0), .mac_f1_c1(mac_f1_c1), .mac_f1_c2(mac_f1_c2)
	);

	channel_sum channel_sum_inst (
		.clk(clk), .rst_n(rst_n), .mac_done(mac_done),
		.mac_f0_c0(mac_f0_c0), .mac_f0_c1(mac_f0_c1), .mac_f0_c2(mac_f0_c2),
		.mac_f1_c0(mac_f1_c0), .mac_f1_c1(mac_f1_c1), .mac_f1_c2(mac_f1_c2),
		.bias_0(bias_0), .bias_1(bias_1), .psum_0(psum_0), .psum_1(psum_1),
		.first_win_row(first_win_row), .win_row_last(win_row_last),
		.psum_pop(psum_pop), .psum_push(psum_push),
		.sum_0(sum_0), .sum_1(sum_1), .sum_vld(sum_vld),
		.fout_vld(fout_vld), .fout_ch0(fout_ch0), .fout_ch1(fout_ch1)
	);

	// one partial sum buffer per output channel
	psum_fifo #(.DEPTH(OUT_W)) psum_fifo_0 (
		.clk(clk), .rst_n(rst_n), .push(psum_push), .pop(psum_pop),
		.din(sum_0), .dout(psum_0)
	);

	psum_fifo #(.DEPTH(OUT_W)) psum_fifo_1 (
		.clk(clk), .rst_n(rst_n), .push(psum_push), .pop(psum_pop),
		.din(sum_1), .dout(psum_1)
	);

	window_counter #(.OUT_W(OUT_W), .KERNEL_H(KERNEL_H), .OUT_H(OUT_H)) window_counter_inst (
		.clk(clk), .rst_n(rst_n), .sum_vld(sum_vld),
		.proc_col(proc_col), .proc_win_row(proc_win_row),
		.proc_row(proc_row), .proc_chnl(proc_chnl),
		.col_last(col_last), .win_row_last(win_row_last),
		.row_last(row_last), .first_win_row(first_win_row)
	);

endmodule

/* test/conv_pe_asserts.sv */
// protocol checks for the convolution PE, bound into the top level
`timescale 1ns/100ps

module conv_pe_asserts #(
	parameter int DEPTH = 4
)
(
	input logic clk,
	input logic rst_n,
	input logic mac_done,
	input logic sum_vld,
	input logic fout_vld,
	input logic psum_push,
	input logic psum_pop
);

	int fail_cnt = 0;	// read by the testbench at the end
	int fill;	// one count for both FIFOs as they move together

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			fill <= 0;
		else
			fill <= fill + int'(psum_push) - int'(psum_pop);
	end

	fout_after_sum: assert property (@(posedge clk) disable iff (!rst_n)
		fout_vld |-> $past(sum_vld))
	else
	begin
		fail_cnt++;
		$error("fout_vld without sum_vld in the cycle before");
	end

	push_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		psum_push && !psum_pop |-> fill < DEPTH)
	else
	begin
		fail_cnt++;
		$error("partial sum push into a full FIFO");
	end

	pop_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		psum_pop |-> fill > 0)
	else
	begin
		fail_cnt++;
		$error("partial sum pop from an empty FIFO");
	end

	// one kernel row needs at least two taps
	mac_done_single: assert property (@(posedge clk) disable iff (!rst_n)
		mac_done |=> !mac_done)
	else
	begin
		fail_cnt++;
		$error("mac_done high on two cycles in a row");
	end

endmodule

bind conv_pe_top conv_pe_asserts #(.DEPTH(OUT_W)) conv_pe_asserts_inst (
	.clk(clk), .rst_n(rst_n), .mac_done(mac_done), .sum_vld(sum_vld),
	.fout_vld(fout_vld), .psum_push(psum_push), .psum_pop(psum_pop)
);

/* test/conv_pe_tb.sv */
// convolution PE testbench that checks random kernel rows against a reference model
`timescale 1ns/100ps

module conv_pe_tb
	import conv_geom_pkg::*, conv_data_pkg::*;
();

	localparam int KW = DEF_KERNEL_W;
	localparam int KH = DEF_KERNEL_H;
	localparam int OW = DEF_OUT_W;
	localparam int OH = DEF_OUT_H;

	logic     clk;
	logic     rst_n;
	logic     tap_vld;
	logic     out_due;	// last tap of a last kernel row group
	sample_t  fin_ch0, fin_ch1, fin_ch2;
	sample_t  wgt_f0_c0, wgt_f0_c1, wgt_f0_c2;
	sample_t  wgt_f1_c0, wgt_f1_c1, wgt_f1_c2;
	acc_t     bias_0, bias_1;
	logic     fout_vld;
	acc_t     fout_ch0, fout_ch1;
	chnl_t    proc_chnl;
	row_t     proc_row;
	col_t     proc_col;
	win_row_t proc_win_row;
	logic     col_last, win_row_last, row_last;

	int         seed = 32'h6c6760ee;
	int         value_errs = 0;
	int         timing_errs = 0;
	int         timeouts = 0;
	int         model_acc [OW][FOUT_PAR];
	acc_t       exp_ch0_q [$];
	acc_t       exp_ch1_q [$];
	col_t       exp_col_q [$];
	row_t       exp_row_q [$];
	logic [2:0] due_pipe;
	col_t       prev_col;
	row_t       prev_row;
	win_row_t   prev_win_row;
	logic       prev_wr_last;
	logic       prev_col_last;
	logic       prev_row_last;

	conv_pe_top conv_pe_top_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic compare_word(input string name, input int got, input int exp);
		assert (got == exp)
		else
		begin
			value_errs++;
			$display("Error %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// position taken one cycle back, while the item sat in the adder stage
	task automatic check_output;
		col_t col;
		row_t row;
		col = exp_col_q.pop_front();
		row = exp_row_q.pop_front();
		compare_word("fout_ch0", fout_ch0, exp_ch0_q.pop_front());
		compare_word("fout_ch1", fout_ch1, exp_ch1_q.pop_front());
		compare_word("proc_col", int'(prev_col), int'(col));
		compare_word("proc_row", int'(prev_row), int'(row));
		compare_word("proc_win_row", int'(prev_win_row), KH - 1);
		compare_word("win_row_last", int'(prev_wr_last), 1);
		compare_word("col_last", int'(prev_col_last), int'(col == col_t'(OW - 1)));
		compare_word("row_last", int'(prev_row_last), int'(row == row_t'(OH - 1)));
	endtask

	always @(posedge clk)
	begin
		if (!rst_n)
			due_pipe <= '0;
		else
		begin
			due_pipe <= {due_pipe[1:0], tap_vld && out_due};	// 3 cycle latency
			assert (fout_vld == due_pipe[2])
			else
			begin
				timing_errs++;
				$display("Error %0t fout_vld got %b expected %b", $time, fout_vld, due_pipe[2]);
			end
			if (fout_vld && exp_ch0_q.size() == 0)
			begin
				value_errs++;
				$display("output at %0t while no result was expected", $time);
			end
			else if (fout_vld)
				check_output();
		end
		prev_col      <= proc_col;
		prev_row      <= proc_row;
		prev_win_row  <= proc_win_row;
		prev_wr_last  <= win_row_last;
		prev_col_last <= col_last;
		prev_row_last <= row_last;
	end

	// one full layer pass, column fastest, then kernel row, then output row
	task automatic run_pass(input bit neg);
		sample_t s [FIN_PAR];
		sample_t w [FOUT_PAR][FIN_PAR];
		acc_t    b [FOUT_PAR];
		int      rnd;
		int      gap;
		b[0] = $random(seed);
		b[1] = neg ? 0 : $random(seed);	// f1 result must come out negative
		@(posedge clk);
		bias_0 <= b[0];
		bias_1 <= b[1];
		for (int orow = 0; orow < OH; orow++)
			for (int krow = 0; krow < KH; krow++)
				for (int col = 0; col < OW; col++)
					for (int tap = 0; tap < KW; tap++)
					begin
						for (int i = 0; i < FIN_PAR; i++)
							s[i] = neg ? sample_t'($unsigned($random(seed)) % 1000 + 1)
								: sample_t'($random(seed));
						for (int o = 0; o < FOUT_PAR; o++)
						begin
							if (krow == 0 && tap == 0)
								model_acc[col][o] = b[o];
							for (int i = 0; i < FIN_PAR; i++)
							begin
								rnd = $unsigned($random(seed)) % 1000 + 1;
								w[o][i] = (neg && o == 1) ? sample_t'(-rnd) : sample_t'($random(seed));
								model_acc[col][o] += int'(s[i]) * int'(w[o][i]);
							end
						end
						@(posedge clk);
						tap_vld   <= 1'b1;
						out_due   <= (krow == KH - 1 && tap == KW - 1);
						fin_ch0   <= s[0];
						fin_ch1   <= s[1];
						fin_ch2   <= s[2];
						wgt_f0_c0 <= w[0][0];
						wgt_f0_c1 <= w[0][1];
						wgt_f0_c2 <= w[0][2];
						wgt_f1_c0 <= w[1][0];
						wgt_f1_c1 <= w[1][1];
						wgt_f1_c2 <= w[1][2];
						if (krow == KH - 1 && tap == KW - 1)
						begin
							exp_ch0_q.push_back(model_acc[col][0] < 0 ? 0 : model_acc[col][0]);
							exp_ch1_q.push_back(model_acc[col][1] < 0 ? 0 : model_acc[col][1]);
							exp_col_q.push_back(col_t'(col));
							exp_row_q.push_back(row_t'(orow));
						end
						gap = $unsigned($random(seed)) % 3;
						repeat (gap)
						begin
							@(posedge clk);
							tap_vld <= 1'b0;
						end
					end
		@(posedge clk);
		tap_vld <= 1'b0;
		out_due <= 1'b0;
	endtask

	task automatic wait_outputs;
		int cnt;
		cnt = 0;
		while (exp_ch0_q.size() != 0 && cnt < 20)
		begin
			@(posedge clk);
			cnt++;
		end
		if (exp_ch0_q.size() != 0)
		begin
			timeouts++;
			$display("timeout at %0t with %0d outputs still missing", $time, exp_ch0_q.size());
		end
	endtask

	initial
	begin
		rst_n     = 1'b0;
		tap_vld   = 1'b0;
		out_due   = 1'b0;
		fin_ch0   = '0;
		fin_ch1   = '0;
		fin_ch2   = '0;
		wgt_f0_c0 = '0;
		wgt_f0_c1 = '0;
		wgt_f0_c2 = '0;
		wgt_f1_c0 = '0;
		wgt_f1_c1 = '0;
		wgt_f1_c2 = '0;
		bias_0    = '0;
		bias_1    = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		// two random passes, then one with a negative f1 sum
		for (int pass = 0; pass < 3; pass++)
		begin
			if (timeouts == 0)
			begin
				run_pass(pass == 2);
				wait_outputs();
				repeat (2) @(posedge clk);
				compare_word("proc_chnl", int'(proc_chnl), pass + 1);
				compare_word("proc_row", int'(proc_row), 0);
				compare_word("proc_col", int'(proc_col), 0);
			end
		end
		$display("errors: %0d value, %0d timing, %0d timeout, %0d protocol", value_errs,
			timing_errs, timeouts, conv_pe_top_inst.conv_pe_asserts_inst.fail_cnt);
		if (value_errs + timing_errs + timeouts
			+ conv_pe_top_inst.conv_pe_asserts_inst.fail_cnt == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* verilog.f */
source/conv_geom_pkg.sv
source/conv_data_pkg.sv
source/mac_array.sv
source/channel_sum.sv
source/psum_fifo.sv
source/window_counter.sv
source/conv_pe_top.sv
test/conv_pe_asserts.sv
test/conv_pe_tb.sv

/* run.sh */
#!/bin/sh
# build the convolution PE testbench with Verilator, run it, check the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module conv_pe_tb \
	-f verilog.f -o conv_pe_sim > build.log 2>&1 &&
	./obj_dir/conv_pe_sim +verilator+error+limit+1000 > sim.log 2>&1
grep -q "Everything OK" sim.log && echo "simulation passed" ||
	{ echo "simulation failed, see build.log and sim.log"; exit 1; }
